// ==== tests/mdio_trace.txt ====
# one setting or command per line, a run line opens each group, settings carry over
# clkdiv N | phyadr HEX | interval_en 0/1 | interval_bit N | abort MDC_EDGES_BEFORE_CLEAR
# write REG_HEX DATA_HEX | read REG_HEX PHY_DATA_HEX ACK (1 = nack)
run
clkdiv 4
phyadr 03
interval_en 0
interval_bit 0
write 00 1234
read 01 abcd 0
write 1f 8001
run
clkdiv 8
phyadr 15
interval_en 1
interval_bit 3
read 02 5a5a 1
read 03 c3c3 0
write 04 ffff
run
clkdiv 6
interval_en 0
read 05 1357 0
abort 52
run
clkdiv 4
phyadr 1f
interval_en 1
interval_bit 0
write 10 0000
read 11 8000 1
run
interval_bit 2
write 12 aaaa
read 13 0f0f 1
abort 20
run
read 14 f00d 0

// ==== list.f ====
logic/mdio_pkg.sv
logic/mdio_bit_timer.sv
logic/mdio_frame_ctrl.sv
logic/mdio_shifter.sv
logic/mdio_master.sv
tests/mdio_tb_clk.sv
tests/mdio_tb.sv

// ==== tests/mdio_tb.sv ====
//====================================================================
// trace driven testbench for the mdio controller
// acts as tx fifo, phy and checker, all driven on the falling edge
// clkdiv, interval_bit and abort are decimal in the trace
// abort gives the mdc rises seen before the clear
//====================================================================

`timescale 1ns/1ps
`default_nettype none

module mdio_tb
	import mdio_pkg::*;
;

	localparam int MAX_CMDS   = 64;
	localparam int MAX_GROUPS = 16;

	logic       pe_clk;
	logic       pe_rstn;
	logic       eth_mdc_o;
	logic       eth_mdio_o;
	logic       eth_mdio_i;
	logic       eth_mdio_oen_o;
	logic       tx_fifo_re_o;
	mdio_cmd_t  tx_fifo_data_i;
	logic       tx_fifo_empty_i;
	logic       rx_fifo_we_o;
	mdio_data_t rx_fifo_data_o;
	logic       pe_master_logic_clr_i;
	logic       pe_master_enable_i;
	mdio_div_t  r_clkdiv_i;
	mdio_addr_t r_phyadr_i;
	mdio_gap_t  r_interval_bit_i;
	logic       r_interval_en_i;
	logic       int_status_rx_turn_nack_o;
	logic       int_status_frame_done_o;

	// trace contents
	mdio_op_t   c_op    [0:MAX_CMDS-1];
	mdio_addr_t c_reg   [0:MAX_CMDS-1];
	mdio_data_t c_data  [0:MAX_CMDS-1];
	logic       c_ack   [0:MAX_CMDS-1];   // 1 = phy nacks
	mdio_div_t  g_div   [0:MAX_GROUPS-1];
	mdio_addr_t g_phy   [0:MAX_GROUPS-1];
	logic       g_ien   [0:MAX_GROUPS-1];
	mdio_gap_t  g_ibit  [0:MAX_GROUPS-1];
	int         g_abort [0:MAX_GROUPS-1]; // -1 = runs to the end
	int         g_first [0:MAX_GROUPS-1];
	int         g_count [0:MAX_GROUPS-1];
	int         n_cmds;
	int         n_groups;

	// run state
	mdio_cmd_t  txq[$];   // fifo model, head is show-ahead data
	mdio_data_t rxq[$];   // expected pushes
	int         grp;
	int         edges;    // mdc rising edges in this group
	int         now_cyc;
	int         last_rise;
	int         re_cnt;
	int         we_cnt;
	int         nack_cnt;
	int         done_cnt;
	logic       pop_pending;
	logic       mdc_prev;
	logic       tail_chk; // bus must be quiet
	int         value_errs;
	int         other_errs;
	int         limit;
	int         cycles;
	int         g;

	mdio_tb_clk u_clk (
		.pe_clk  (pe_clk),
		.pe_rstn (pe_rstn)
	);

	mdio_master dut (
		.pe_clk                    (pe_clk),
		.pe_rstn                   (pe_rstn),
		.eth_mdc_o                 (eth_mdc_o),
		.eth_mdio_o                (eth_mdio_o),
		.eth_mdio_i                (eth_mdio_i),
		.eth_mdio_oen_o            (eth_mdio_oen_o),
		.tx_fifo_re_o              (tx_fifo_re_o),
		.tx_fifo_data_i            (tx_fifo_data_i),
		.tx_fifo_empty_i           (tx_fifo_empty_i),
		.rx_fifo_we_o              (rx_fifo_we_o),
		.rx_fifo_data_o            (rx_fifo_data_o),
		.pe_master_logic_clr_i     (pe_master_logic_clr_i),
		.pe_master_enable_i        (pe_master_enable_i),
		.r_clkdiv_i                (r_clkdiv_i),
		.r_phyadr_i                (r_phyadr_i),
		.r_interval_bit_i          (r_interval_bit_i),
		.r_interval_en_i           (r_interval_en_i),
		.int_status_rx_turn_nack_o (int_status_rx_turn_nack_o),
		.int_status_frame_done_o   (int_status_frame_done_o)
	);

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		$display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
		value_errs++;
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		other_errs++;
	endtask

	//================================================================
	// trace loading
	//================================================================

	task automatic load_trace();
		int    fd;
		int    n;
		int    a;
		int    b;
		int    c;
		int    d;
		int    k;
		string line;
		string kw;
		fd = $fopen("tests/mdio_trace.txt", "r");
		if (fd == 0)
			report_problem("cannot open tests/mdio_trace.txt");
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				kw = "";
				n  = $sscanf(line, "%s", kw);
				if (n >= 1 && kw.getc(0) != "#") // skip blanks and comments
				begin
					n = $sscanf(line, "%s %h %h %h", kw, a, b, c);
					if ($sscanf(line, "%s %d", kw, d) < 2)
						d = 0; // decimal view of the first value
					if (kw == "run")
					begin
						n_groups++;
						g_first[n_groups-1] = n_cmds;
						g_count[n_groups-1] = 0;
						g_abort[n_groups-1] = -1;
					end
					else if (n_groups == 0)
						report_problem("trace line before the first run marker");
					else if (kw == "clkdiv")
						g_div[n_groups-1] = d;
					else if (kw == "phyadr")
						g_phy[n_groups-1] = a;
					else if (kw == "interval_en")
						g_ien[n_groups-1] = a[0];
					else if (kw == "interval_bit")
						g_ibit[n_groups-1] = d;
					else if (kw == "abort")
						g_abort[n_groups-1] = d;
					else if (kw == "write" || kw == "read")
					begin
						c_op[n_cmds]   = (kw == "read") ? MDIO_OP_READ : MDIO_OP_WRITE;
						c_reg[n_cmds]  = a;
						c_data[n_cmds] = b;
						c_ack[n_cmds]  = (kw == "read") ? c[0] : 1'b0;
						n_cmds++;
						g_count[n_groups-1]++;
					end
					else
						report_problem({"unknown trace line: ", kw});
				end
				// settings carry over into the next group
				if (kw == "run" && n_groups > 1)
				begin
					g_div[n_groups-1]  = g_div[n_groups-2];
					g_phy[n_groups-1]  = g_phy[n_groups-2];
					g_ien[n_groups-1]  = g_ien[n_groups-2];
					g_ibit[n_groups-1] = g_ibit[n_groups-2];
				end
			end
			$fclose(fd);
		end
		// run limit from the frame lengths
		limit = 200;
		for (k = 0; k < n_groups; k++)
			limit += 2 * g_count[k] * (64 + (g_ien[k] ? int'(g_ibit[k]) : 0)) * g_div[k];
	endtask

	//================================================================
	// per cycle model and checks
	//================================================================

	// 64 wire bits of one frame, first bit on the wire at [63]
	function automatic logic [63:0] expected_frame(input int c);
		expected_frame = {32'hffff_ffff, 2'b01, c_op[c], g_phy[grp], c_reg[c], 2'b10, c_data[c]};
	endfunction

	// phy answer for a given edge of the group
	function automatic logic phy_bit(input int e);
		int f;
		int idx;
		int c;
		f   = e / 64;
		idx = e % 64;
		c   = g_first[grp] + f;
		phy_bit = 1'b1; // pull-up
		if (f < g_count[grp] && c_op[c] == MDIO_OP_READ)
		begin
			if (idx == 47)
				phy_bit = c_ack[c];
			else if (idx >= 48)
				phy_bit = c_data[c][63-idx];
		end
	endfunction

	task automatic check_edge();
		int          f;
		int          idx;
		int          c;
		int          gap_exp;
		logic [63:0] fr;
		logic        rd;
		f   = edges / 64;
		idx = edges % 64;
		if (f >= g_count[grp])
			report_problem("MDC edge after the last frame of the group");
		else
		begin
			c  = g_first[grp] + f;
			fr = expected_frame(c);
			rd = (c_op[c] == MDIO_OP_READ);
			if ((!rd || idx < 46) && eth_mdio_o !== fr[63-idx])
				report_mismatch("eth_mdio_o", fr[63-idx], eth_mdio_o);
			if (eth_mdio_oen_o !== (rd && idx >= 46)) // released from turnaround on reads
				report_mismatch("eth_mdio_oen_o", rd && idx >= 46, eth_mdio_oen_o);
			if (idx == 0 && f > 0)
			begin
				gap_exp = g_div[grp] * (1 + (g_ien[grp] ? int'(g_ibit[grp]) : 0));
				if (now_cyc - last_rise != gap_exp)
					report_mismatch("frame spacing", gap_exp, now_cyc - last_rise);
			end
			if (idx == 63)
				last_rise = now_cyc;
		end
		edges++;
	endtask

	task automatic drive_fifo();
		tx_fifo_empty_i = (txq.size() == 0);
		tx_fifo_data_i  = (txq.size() > 0) ? txq[0] : '0;
	endtask

	task automatic step();
		mdio_cmd_t  dropped;
		mdio_data_t exp_rx;
		now_cyc++;
		// pop one cycle after the read enable, word was latched by then
		if (pop_pending && txq.size() > 0)
			dropped = txq.pop_front();
		pop_pending = 1'b0;
		if (tx_fifo_re_o)
		begin
			re_cnt++;
			if (txq.size() == 0)
				report_problem("transmit FIFO read while empty");
			else
				pop_pending = 1'b1;
		end
		if (eth_mdc_o && !mdc_prev)
		begin
			check_edge();
			eth_mdio_i = phy_bit(edges); // ready well before the next rise
		end
		mdc_prev = eth_mdc_o;
		if (rx_fifo_we_o)
		begin
			we_cnt++;
			if (rxq.size() == 0)
				report_problem("receive FIFO push with no read pending");
			else
			begin
				exp_rx = rxq.pop_front();
				if (rx_fifo_data_o !== exp_rx)
					report_mismatch("rx_fifo_data_o", exp_rx, rx_fifo_data_o);
			end
		end
		if (int_status_rx_turn_nack_o)
			nack_cnt++;
		if (int_status_frame_done_o)
			done_cnt++;
		if (tail_chk)
		begin
			if (eth_mdc_o !== 1'b0)
				report_mismatch("eth_mdc_o", 1'b0, eth_mdc_o);
			if (eth_mdio_oen_o !== 1'b1)
				report_mismatch("eth_mdio_oen_o", 1'b1, eth_mdio_oen_o);
		end
		drive_fifo();
	endtask

	task automatic next_cycle();
		@(negedge pe_clk);
		step();
	endtask

	//================================================================
	// one trace group
	//================================================================

	task automatic run_group(input int gi);
		int k;
		int c;
		int n_rd;
		int n_nack;
		int n_frames;
		int n_edges;
		bit cut;
		grp  = gi;
		cut  = (g_abort[gi] >= 0);
		r_clkdiv_i       = g_div[gi];
		r_phyadr_i       = g_phy[gi];
		r_interval_en_i  = g_ien[gi];
		r_interval_bit_i = g_ibit[gi];
		edges     = 0;
		last_rise = 0;
		re_cnt    = 0;
		we_cnt    = 0;
		nack_cnt  = 0;
		done_cnt  = 0;
		n_rd      = 0;
		n_nack    = 0;
		txq.delete();
		rxq.delete();
		for (k = 0; k < g_count[gi]; k++)
		begin
			c = g_first[gi] + k;
			txq.push_back({c_op[c], c_reg[c], c_data[c]});
			if (c_op[c] == MDIO_OP_READ)
			begin
				// pushed only once the next frame has begun before the clear
				if (!cut || g_abort[gi] > 64 * k + 64)
				begin
					rxq.push_back(c_data[c]);
					n_rd++;
				end
				// nack counts only if the ack edge came before the clear
				if (c_ack[c] && (!cut || g_abort[gi] >= 64 * k + 48))
					n_nack++;
			end
		end
		n_frames = g_count[gi];
		if (cut && (g_abort[gi] + 63) / 64 < n_frames)
			n_frames = (g_abort[gi] + 63) / 64;
		n_edges = cut ? g_abort[gi] : 64 * g_count[gi];
		eth_mdio_i = 1'b1;
		drive_fifo();
		pe_master_enable_i = 1'b1;
		if (cut)
		begin
			while (edges < g_abort[gi])
				next_cycle();
			pe_master_logic_clr_i = 1'b1;
			pe_master_enable_i    = 1'b0;
			txq.delete(); // host flushes what is left
			drive_fifo();
			next_cycle();
			pe_master_logic_clr_i = 1'b0;
		end
		else
		begin
			while (done_cnt == 0)
				next_cycle();
			pe_master_enable_i = 1'b0;
		end
		next_cycle(); // mdc and pin settle
		next_cycle();
		tail_chk = 1'b1;
		for (k = 0; k < 2 * g_div[gi]; k++)
			next_cycle();
		tail_chk = 1'b0;
		if (re_cnt != n_frames)
			report_mismatch("tx_fifo_re_o pulses", n_frames, re_cnt);
		if (we_cnt != n_rd)
			report_mismatch("rx_fifo_we_o pulses", n_rd, we_cnt);
		if (nack_cnt != n_nack)
			report_mismatch("int_status_rx_turn_nack_o pulses", n_nack, nack_cnt);
		if (done_cnt != (cut ? 0 : 1))
			report_mismatch("int_status_frame_done_o pulses", cut ? 0 : 1, done_cnt);
		if (edges != n_edges)
			report_mismatch("eth_mdc_o rising edges", n_edges, edges);
	endtask

	// watchdog
	always @(posedge pe_clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			other_errs++;
			$display("ERROR t=%0t run passed its limit of %0d cycles", $time, limit);
			$display("errors: %0d wrong values, %0d other", value_errs, other_errs);
			$display("Done: errors found");
			$finish;
		end
	end

	initial
	begin
		eth_mdio_i            = 1'b1;
		tx_fifo_data_i        = '0;
		tx_fifo_empty_i       = 1'b1;
		pe_master_logic_clr_i = 1'b0;
		pe_master_enable_i    = 1'b0;
		r_clkdiv_i            = 8'd4;
		r_phyadr_i            = '0;
		r_interval_bit_i      = '0;
		r_interval_en_i       = 1'b0;
		pop_pending = 1'b0;
		mdc_prev    = 1'b0;
		tail_chk    = 1'b0;
		now_cyc     = 0;
		cycles      = 0;
		value_errs  = 0;
		other_errs  = 0;
		n_cmds      = 0;
		n_groups    = 0;
		grp         = 0;
		load_trace();
		@(posedge pe_rstn);
		@(negedge pe_clk);
		// quiet bus out of reset
		if (tx_fifo_re_o !== 1'b0)
			report_mismatch("tx_fifo_re_o", 1'b0, tx_fifo_re_o);
		if (rx_fifo_we_o !== 1'b0)
			report_mismatch("rx_fifo_we_o", 1'b0, rx_fifo_we_o);
		if (int_status_rx_turn_nack_o !== 1'b0)
			report_mismatch("int_status_rx_turn_nack_o", 1'b0, int_status_rx_turn_nack_o);
		if (int_status_frame_done_o !== 1'b0)
			report_mismatch("int_status_frame_done_o", 1'b0, int_status_frame_done_o);
		if (eth_mdc_o !== 1'b0)
			report_mismatch("eth_mdc_o", 1'b0, eth_mdc_o);
		if (eth_mdio_o !== 1'b1)
			report_mismatch("eth_mdio_o", 1'b1, eth_mdio_o);
		if (eth_mdio_oen_o !== 1'b1)
			report_mismatch("eth_mdio_oen_o", 1'b1, eth_mdio_oen_o);
		for (g = 0; g < n_groups; g++)
			run_group(g);
		$display("errors: %0d wrong values, %0d other", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/mdio_tb_clk.sv ====
//====================================================================
// testbench clock and reset, 4 ns period
// reset low for the first 2 clock cycles, released on a falling edge
//====================================================================

`timescale 1ns/1ps
`default_nettype none

module mdio_tb_clk (
	output logic pe_clk,
	output logic pe_rstn
);

	initial
	begin
		pe_clk = 1'b0;
		forever
			#2 pe_clk = ~pe_clk; // half period
	end

	initial
	begin
		pe_rstn = 1'b0;
		#8 pe_rstn = 1'b1; // two rising edges in reset
	end

endmodule

`default_nettype wire

// ==== logic/mdio_master.sv ====
//====================================================================
// management bus controller top level
// mdc is always driven, no output enable
// no back-pressure from the receive fifo
//====================================================================

`timescale 1ns/1ps
`default_nettype none

module mdio_master
	import mdio_pkg::*;
(
	input  logic       pe_clk,
	input  logic       pe_rstn,
	// pins
	output logic       eth_mdc_o,
	output logic       eth_mdio_o,
	input  logic       eth_mdio_i,
	output logic       eth_mdio_oen_o,
	// fifos
	output logic       tx_fifo_re_o,
	input  mdio_cmd_t  tx_fifo_data_i,
	input  logic       tx_fifo_empty_i,
	output logic       rx_fifo_we_o,
	output mdio_data_t rx_fifo_data_o,
	// control and config
	input  logic       pe_master_logic_clr_i,
	input  logic       pe_master_enable_i,
	input  mdio_div_t  r_clkdiv_i,
	input  mdio_addr_t r_phyadr_i,
	input  mdio_gap_t  r_interval_bit_i,
	input  logic       r_interval_en_i,
	// interrupt status
	output logic       int_status_rx_turn_nack_o,
	output logic       int_status_frame_done_o
);

	logic        timer_run;
	logic        mdc_run;
	logic        bit_end;
	logic        sample_point;
	logic        frame_start;
	logic        read_done;
	mdio_field_t field;
	logic [5:0]  field_bit;
	mdio_op_t    op;
	mdio_addr_t  regad;
	mdio_data_t  wdata;

	mdio_bit_timer u_timer (
		.pe_clk         (pe_clk),
		.pe_rstn        (pe_rstn),
		.timer_run_i    (timer_run),
		.mdc_run_i      (mdc_run),
		.r_clkdiv_i     (r_clkdiv_i),
		.bit_end_o      (bit_end),
		.sample_point_o (sample_point),
		.eth_mdc_o      (eth_mdc_o)
	);

	mdio_frame_ctrl u_ctrl (
		.pe_clk                  (pe_clk),
		.pe_rstn                 (pe_rstn),
		.bit_end_i               (bit_end),
		.pe_master_enable_i      (pe_master_enable_i),
		.pe_master_logic_clr_i   (pe_master_logic_clr_i),
		.tx_fifo_empty_i         (tx_fifo_empty_i),
		.tx_fifo_data_i          (tx_fifo_data_i),
		.r_interval_en_i         (r_interval_en_i),
		.r_interval_bit_i        (r_interval_bit_i),
		.tx_fifo_re_o            (tx_fifo_re_o),
		.timer_run_o             (timer_run),
		.mdc_run_o               (mdc_run),
		.frame_start_o           (frame_start),
		.field_o                 (field),
		.field_bit_o             (field_bit),
		.op_o                    (op),
		.regad_o                 (regad),
		.wdata_o                 (wdata),
		.read_done_o             (read_done),
		.int_status_frame_done_o (int_status_frame_done_o)
	);

	mdio_shifter u_shift (
		.pe_clk                    (pe_clk),
		.pe_rstn                   (pe_rstn),
		.bit_end_i                 (bit_end),
		.sample_point_i            (sample_point),
		.frame_start_i             (frame_start),
		.read_done_i               (read_done),
		.field_i                   (field),
		.field_bit_i               (field_bit),
		.op_i                      (op),
		.regad_i                   (regad),
		.wdata_i                   (wdata),
		.r_phyadr_i                (r_phyadr_i),
		.eth_mdio_i                (eth_mdio_i),
		.eth_mdio_o                (eth_mdio_o),
		.eth_mdio_oen_o            (eth_mdio_oen_o),
		.rx_fifo_we_o              (rx_fifo_we_o),
		.rx_fifo_data_o            (rx_fifo_data_o),
		.int_status_rx_turn_nack_o (int_status_rx_turn_nack_o)
	);

endmodule

`default_nettype wire

// ==== logic/mdio_shifter.sv ====
//====================================================================
// mdio pin drive and read capture
// pin released and parked high outside frames and in the gap
// read data arrives msb first, pushed even when the phy nacks
// rx fifo must always accept the push
//====================================================================

`timescale 1ns/1ps
`default_nettype none

module mdio_shifter
	import mdio_pkg::*;
(
	input  logic        pe_clk,
	input  logic        pe_rstn,
	input  logic        bit_end_i,
	input  logic        sample_point_i,
	input  logic        frame_start_i,
	input  logic        read_done_i,
	input  mdio_field_t field_i,
	input  logic [5:0]  field_bit_i,
	input  mdio_op_t    op_i,
	input  mdio_addr_t  regad_i,
	input  mdio_data_t  wdata_i,
	input  mdio_addr_t  r_phyadr_i,
	input  logic        eth_mdio_i,
	output logic        eth_mdio_o,
	output logic        eth_mdio_oen_o,   // 1 = released
	output logic        rx_fifo_we_o,
	output mdio_data_t  rx_fifo_data_o,
	output logic        int_status_rx_turn_nack_o
);

	logic                        is_read;
	logic [MDIO_OPADDR_BITS-1:0] opaddr;
	logic                        drv_bit;
	logic                        drv_en;
	logic                        mdio_q;
	logic                        oen_q;
	logic                        smp_q;
	mdio_data_t                  rx_sr_q;
	mdio_data_t                  rx_data_q;
	logic                        rx_we_q;
	logic                        nack_q;

	assign is_read = (op_i == MDIO_OP_READ);
	assign opaddr  = {op_i, r_phyadr_i, regad_i}; // wire order, msb first

	//================================================================
	// output bit select
	//================================================================

	always_comb
	begin
		drv_bit = 1'b1; // parked value when released
		drv_en  = 1'b0;
		case (field_i)
			FLD_PREAMBLE:
			begin
				// all ones except first start bit
				drv_bit = (field_bit_i != 6'(MDIO_PREAMBLE_BITS));
				drv_en  = 1'b1;
			end
			FLD_OPADDR:
			begin
				drv_bit = opaddr[4'(MDIO_OPADDR_BITS - 1) - field_bit_i[3:0]];
				drv_en  = 1'b1;
			end
			FLD_TURN:
			begin
				if (!is_read)
				begin
					drv_bit = ~field_bit_i[0]; // 1 then 0
					drv_en  = 1'b1;
				end
			end
			FLD_DATA:
			begin
				if (!is_read)
				begin
					drv_bit = wdata_i[4'(MDIO_DATA_BITS - 1) - field_bit_i[3:0]];
					drv_en  = 1'b1;
				end
			end
			default:
			begin
				drv_bit = 1'b1;
				drv_en  = 1'b0;
			end
		endcase
	end

	// pin registers, change while mdc is low
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			mdio_q <= 1'b1;
			oen_q  <= 1'b1;
		end
		else
		begin
			mdio_q <= drv_bit;
			oen_q  <= ~drv_en;
		end
	end

	//================================================================
	// read capture
	//================================================================

	// pin value at the sample point, held until the bit ends
	always_ff @(posedge pe_clk)
	begin
		if (sample_point_i)
			smp_q <= eth_mdio_i;
	end

	always_ff @(posedge pe_clk)
	begin
		if (frame_start_i)
			rx_sr_q <= '0;
		else if (bit_end_i && (field_i == FLD_DATA) && is_read)
			rx_sr_q <= {rx_sr_q[MDIO_DATA_BITS-2:0], smp_q};
	end

	// last bit joins the word on the push
	always_ff @(posedge pe_clk)
	begin
		if (read_done_i)
			rx_data_q <= {rx_sr_q[MDIO_DATA_BITS-2:0], smp_q};
	end

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			rx_we_q <= 1'b0;
			nack_q  <= 1'b0;
		end
		else
		begin
			rx_we_q <= read_done_i;
			// ack is the second turnaround bit, low from the phy
			nack_q  <= sample_point_i && (field_i == FLD_TURN) && is_read
				&& (field_bit_i == 6'(MDIO_TURN_BITS - 1)) && eth_mdio_i;
		end
	end

	assign eth_mdio_o                = mdio_q;
	assign eth_mdio_oen_o            = oen_q;
	assign rx_fifo_we_o              = rx_we_q;
	assign rx_fifo_data_o            = rx_data_q;
	assign int_status_rx_turn_nack_o = nack_q;

endmodule

`default_nettype wire

// ==== logic/mdio_frame_ctrl.sv ====
//====================================================================
// frame sequencer: steps the fields, times the gap, loads commands
// tx fifo is show-ahead, one word popped per frame
// opcodes other than read go out as write
// r_interval_bit_i of zero behaves as no gap
//====================================================================

`timescale 1ns/1ps
`default_nettype none

module mdio_frame_ctrl
	import mdio_pkg::*;
(
	input  logic        pe_clk,
	input  logic        pe_rstn,
	input  logic        bit_end_i,
	input  logic        pe_master_enable_i,
	input  logic        pe_master_logic_clr_i,  // abort, back to idle next clock
	input  logic        tx_fifo_empty_i,
	input  mdio_cmd_t   tx_fifo_data_i,
	input  logic        r_interval_en_i,
	input  mdio_gap_t   r_interval_bit_i,
	output logic        tx_fifo_re_o,
	output logic        timer_run_o,
	output logic        mdc_run_o,
	output logic        frame_start_o,
	output mdio_field_t field_o,
	output logic [5:0]  field_bit_o,            // bit index inside field
	output mdio_op_t    op_o,
	output mdio_addr_t  regad_o,
	output mdio_data_t  wdata_o,
	output logic        read_done_o,            // last read data bit done
	output logic        int_status_frame_done_o
);

	mdio_state_t st_q;
	mdio_state_t st_nxt;
	logic [5:0]  bit_cnt_q;
	logic [5:0]  field_last;
	logic        in_field;
	logic        field_end;
	mdio_gap_t   gap_cnt_q;
	logic        gap_on;
	logic        gap_end;
	logic        start_q;
	mdio_op_t    cmd_op;
	mdio_op_t    op_q;
	mdio_addr_t  regad_q;
	mdio_data_t  wdata_q;

	assign in_field = (st_q == ST_PREAMBLE) || (st_q == ST_OPADDR) || (st_q == ST_TURN)
		|| (st_q == ST_WRITE) || (st_q == ST_READ);

	// last bit index of the field in progress
	always_comb
	begin
		case (st_q)
			ST_PREAMBLE:       field_last = 6'(MDIO_PRE_FIELD_BITS - 1);
			ST_OPADDR:         field_last = 6'(MDIO_OPADDR_BITS - 1);
			ST_TURN:           field_last = 6'(MDIO_TURN_BITS - 1);
			ST_WRITE, ST_READ: field_last = 6'(MDIO_DATA_BITS - 1);
			default:           field_last = '0;
		endcase
	end

	assign field_end = bit_end_i && in_field && (bit_cnt_q == field_last);

	// gap only when enabled and nonzero
	assign gap_on  = r_interval_en_i && (r_interval_bit_i != '0);
	assign gap_end = bit_end_i && (st_q == ST_GAP) && (gap_cnt_q == r_interval_bit_i - 8'd1);

	//================================================================
	// state machine
	//================================================================

	always_comb
	begin
		st_nxt = st_q;
		case (st_q)
			ST_IDLE:
				if (pe_master_enable_i && !tx_fifo_empty_i)
					st_nxt = ST_PREAMBLE;
			ST_PREAMBLE:
				if (field_end)
					st_nxt = ST_OPADDR;
			ST_OPADDR:
				if (field_end)
					st_nxt = ST_TURN;
			ST_TURN:
				if (field_end)
					st_nxt = (op_q == MDIO_OP_READ) ? ST_READ : ST_WRITE;
			ST_WRITE, ST_READ:
			begin
				if (field_end)
				begin
					if (gap_on)
						st_nxt = ST_GAP;
					else if (tx_fifo_empty_i)
						st_nxt = ST_DONE;
					else
						st_nxt = ST_PREAMBLE; // back to back
				end
			end
			ST_GAP:
				if (gap_end)
					st_nxt = tx_fifo_empty_i ? ST_DONE : ST_PREAMBLE;
			ST_DONE:
				st_nxt = ST_IDLE; // single cycle
			default:
				st_nxt = ST_IDLE;
		endcase
		if (pe_master_logic_clr_i)
			st_nxt = ST_IDLE; // clear beats everything
	end

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			st_q <= ST_IDLE;
		else
			st_q <= st_nxt;
	end

	//================================================================
	// bit and interval counters
	//================================================================

	// one counter shared by all fields, restarts at each field end
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			bit_cnt_q <= '0;
		else if (pe_master_logic_clr_i || field_end || !in_field)
			bit_cnt_q <= '0;
		else if (bit_end_i)
			bit_cnt_q <= bit_cnt_q + 6'd1;
	end

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			gap_cnt_q <= '0;
		else if (pe_master_logic_clr_i || (st_q != ST_GAP))
			gap_cnt_q <= '0;
		else if (bit_end_i)
			gap_cnt_q <= gap_cnt_q + 8'd1; // idle bits elapsed
	end

	//================================================================
	// command load
	//================================================================

	// high in the first cycle of every preamble
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			start_q <= 1'b0;
		else
			start_q <= (st_nxt == ST_PREAMBLE) && (st_q != ST_PREAMBLE);
	end

	assign cmd_op = tx_fifo_data_i[MDIO_CMD_OP_LSB +: MDIO_OP_BITS];

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			op_q <= MDIO_OP_WRITE;
		else if (start_q)
			op_q <= (cmd_op == MDIO_OP_READ) ? MDIO_OP_READ : MDIO_OP_WRITE;
	end

	always_ff @(posedge pe_clk)
	begin
		if (start_q)
		begin
			regad_q <= tx_fifo_data_i[MDIO_CMD_REG_LSB +: MDIO_ADDR_BITS];
			wdata_q <= tx_fifo_data_i[MDIO_DATA_BITS-1:0]; // unused on reads
		end
	end

	// field seen by the shifter
	always_comb
	begin
		case (st_q)
			ST_PREAMBLE:       field_o = FLD_PREAMBLE;
			ST_OPADDR:         field_o = FLD_OPADDR;
			ST_TURN:           field_o = FLD_TURN;
			ST_WRITE, ST_READ: field_o = FLD_DATA;
			default:           field_o = FLD_NONE;
		endcase
	end

	assign tx_fifo_re_o  = start_q; // pop as the word is latched
	assign frame_start_o = start_q;
	assign timer_run_o   = in_field || (st_q == ST_GAP);
	assign mdc_run_o     = in_field;
	assign field_bit_o   = bit_cnt_q;
	assign op_o          = op_q;
	assign regad_o       = regad_q;
	assign wdata_o       = wdata_q;

	// no push for a read cut short by clear
	assign read_done_o = field_end && (st_q == ST_READ) && !pe_master_logic_clr_i;
	assign int_status_frame_done_o = (st_q == ST_DONE);

endmodule

`default_nettype wire

// ==== logic/mdio_bit_timer.sv ====
//====================================================================
// bit timing base for the management bus
// r_clkdiv_i must be even and at least 4
// mdc low in first half of a bit, high in second half
//====================================================================

`timescale 1ns/1ps
`default_nettype none

module mdio_bit_timer
	import mdio_pkg::*;
(
	input  logic      pe_clk,
	input  logic      pe_rstn,
	input  logic      timer_run_i,     // frame or gap in progress
	input  logic      mdc_run_i,       // clock allowed on the pin
	input  mdio_div_t r_clkdiv_i,
	output logic      bit_end_o,       // last sys clock of a bit
	output logic      sample_point_o,  // cycle before mdc rises
	output logic      eth_mdc_o
);

	mdio_div_t div_cnt_q;
	mdio_div_t half_div;
	logic      bit_end;
	logic      sample_point;
	logic      mdc_q;

	assign half_div = r_clkdiv_i >> 1;

	// decode, only meaningful while running
	assign bit_end      = timer_run_i && (div_cnt_q == r_clkdiv_i - 8'd1);
	assign sample_point = timer_run_i && (div_cnt_q == half_div - 8'd1);

	//================================================================
	// divide counter
	//================================================================

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			div_cnt_q <= '0;
		else if (!timer_run_i || bit_end)
			div_cnt_q <= '0; // idle or wrap at bit boundary
		else
			div_cnt_q <= div_cnt_q + 8'd1;
	end

	// mdc generation
	// rises right after the sample point, falls with the bit end
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			mdc_q <= 1'b0;
		else if (!mdc_run_i)
			mdc_q <= 1'b0; // held low in gap and idle
		else if (bit_end)
			mdc_q <= 1'b0;
		else if (sample_point)
			mdc_q <= 1'b1;
	end

	assign bit_end_o      = bit_end;
	assign sample_point_o = sample_point;
	assign eth_mdc_o      = mdc_q;

endmodule

`default_nettype wire

// ==== logic/mdio_pkg.sv ====
//====================================================================
// shared widths, command word layout and state encodings
// command word: [22:21] opcode, [20:16] register address, [15:0] data
// frame is always the full 64 bit form, no short preamble
//====================================================================

`default_nettype none

package mdio_pkg;

	// field lengths on the wire
	localparam int MDIO_PREAMBLE_BITS = 32;
	localparam int MDIO_START_BITS    = 2;
	localparam int MDIO_OP_BITS       = 2;
	localparam int MDIO_ADDR_BITS     = 5;
	localparam int MDIO_TURN_BITS     = 2;
	localparam int MDIO_DATA_BITS     = 16;

	localparam int MDIO_PRE_FIELD_BITS = MDIO_PREAMBLE_BITS + MDIO_START_BITS; // preamble + start
	localparam int MDIO_OPADDR_BITS    = MDIO_OP_BITS + 2 * MDIO_ADDR_BITS;    // op, phy, reg
	localparam int MDIO_FRAME_BITS     = MDIO_PRE_FIELD_BITS + MDIO_OPADDR_BITS
		+ MDIO_TURN_BITS + MDIO_DATA_BITS;                                     // 64

	// command word bit positions
	localparam int MDIO_CMD_OP_LSB  = MDIO_ADDR_BITS + MDIO_DATA_BITS;
	localparam int MDIO_CMD_REG_LSB = MDIO_DATA_BITS;

	typedef logic [MDIO_OP_BITS-1:0]   mdio_op_t;
	typedef logic [MDIO_ADDR_BITS-1:0] mdio_addr_t;  // phy or register address
	typedef logic [MDIO_DATA_BITS-1:0] mdio_data_t;
	typedef logic [7:0]                mdio_div_t;   // sys clocks per mdc bit
	typedef logic [7:0]                mdio_gap_t;   // idle bits between frames
	typedef logic [MDIO_OP_BITS+MDIO_ADDR_BITS+MDIO_DATA_BITS-1:0] mdio_cmd_t;

	localparam mdio_op_t MDIO_OP_WRITE = 2'b01;
	localparam mdio_op_t MDIO_OP_READ  = 2'b10;

	// field currently on the wire
	typedef enum logic [2:0] {
		FLD_NONE,
		FLD_PREAMBLE,   // also carries the two start bits
		FLD_OPADDR,
		FLD_TURN,
		FLD_DATA
	} mdio_field_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_OPADDR,
		ST_TURN,
		ST_WRITE,
		ST_READ,
		ST_GAP,
		ST_DONE
	} mdio_state_t;

endpackage

`default_nettype wire
